/* aes_encipher_core.sv */
// AES-128 encipher core top: controller, round datapath and
// the shared S-box
`default_nettype none
`include "aes_settings.svh"

module aes_encipher_core
  import aes_types_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  reset_n,
  input  wire logic                  next,
  input  wire aes_block_t            block,
  input  wire aes_block_t            round_key,
  output wire [`AES_ROUND_BITS-1:0]  round,
  output wire aes_block_t            new_block,
  output wire logic                  ready
);

  // controller to datapath
  aes_round_op_e round_op;
  logic [1:0]    sword_idx;
  // datapath to S-box and back
  aes_word_t     sbox_in;
  aes_word_t     sbox_out;

  aes_encipher_ctrl u_ctrl (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .round_op  (round_op),
    .sword_idx (sword_idx),
    .round     (round),
    .ready     (ready)
  );

  aes_round_datapath u_datapath (
    .clk       (clk),
    .reset_n   (reset_n),
    .round_op  (round_op),
    .sword_idx (sword_idx),
    .block     (block),
    .round_key (round_key),
    .sbox_out  (sbox_out),
    .sbox_in   (sbox_in),
    .new_block (new_block)
  );

  // one S-box, shared by all rounds
  aes_sbox u_sbox (
    .word_in  (sbox_in),
    .word_out (sbox_out)
  );

endmodule

`default_nettype wire

/* aes_encipher_ctrl.sv */
// encipher control FSM with round counter, SubBytes word
// counter and the ready flag
`default_nettype none
`include "aes_settings.svh"

module aes_encipher_ctrl
  import aes_types_pkg::*;
(
  input  wire logic                   clk,
  input  wire logic                   reset_n,
  input  wire logic                   next,
  output aes_round_op_e               round_op,
  output logic [1:0]                  sword_idx,
  output logic [`AES_ROUND_BITS-1:0]  round,
  output logic                        ready
);

  localparam logic [`AES_ROUND_BITS-1:0] LAST_ROUND = `AES_ROUND_BITS'(`AES_ROUNDS);

  aes_ctrl_state_e            state_reg;
  aes_ctrl_state_e            state_next;
  logic [`AES_ROUND_BITS-1:0] round_ctr;
  logic [1:0]                 sword_ctr;
  logic                       ready_reg;

  // -------------------------------------------------------------------------
  // next state and datapath opcode
  // -------------------------------------------------------------------------
  always_comb
  begin
    state_next = state_reg;
    round_op   = OP_HOLD;
    case (state_reg)
      // round counter rests at 0 here so key 0 is already on round_key
      CTRL_IDLE:
        if (next)
        begin
          state_next = CTRL_INIT;
          round_op   = OP_INIT;
        end
      // key lookup turns over to round 1
      CTRL_INIT:
        state_next = CTRL_SUB;
      CTRL_SUB:
      begin
        round_op = OP_SUB;
        if (sword_ctr == 2'd3)
          state_next = CTRL_UPDATE;
      end
      CTRL_UPDATE:
        if (round_ctr == LAST_ROUND)
        begin
          round_op   = OP_FINAL;
          state_next = CTRL_IDLE;
        end
        else
        begin
          round_op   = OP_MAIN;
          state_next = CTRL_SUB;
        end
    endcase
  end

  // -------------------------------------------------------------------------
  // registers
  // -------------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state_reg <= CTRL_IDLE;
      round_ctr <= '0;
      sword_ctr <= '0;
      ready_reg <= 1'b0;
    end
    else
    begin
      state_reg <= state_next;
      case (state_reg)
        CTRL_IDLE:
          if (next)
            ready_reg <= 1'b0;
        // entry to round 1
        CTRL_INIT:
        begin
          round_ctr <= `AES_ROUND_BITS'(1);
          sword_ctr <= '0;
        end
        // wraps back to 0 after column 3
        CTRL_SUB:
          sword_ctr <= sword_ctr + 2'd1;
        CTRL_UPDATE:
          if (round_ctr == LAST_ROUND)
          begin
            round_ctr <= '0;
            ready_reg <= 1'b1;
          end
          else
            round_ctr <= round_ctr + `AES_ROUND_BITS'(1);
      endcase
    end
  end

  assign sword_idx = sword_ctr;
  assign round     = round_ctr;
  assign ready     = ready_reg;

  // counter never runs past the last round
  a_round_range: assert property (@(posedge clk) disable iff (!reset_n)
    round_ctr <= LAST_ROUND);

  // done flag only while waiting for a new block
  a_ready_idle: assert property (@(posedge clk) disable iff (!reset_n)
    ready_reg |-> state_reg == CTRL_IDLE);

endmodule

`default_nettype wire

/* aes_gf_pkg.sv */
// GF(2^8) arithmetic for MixColumns
`default_nettype none
`include "aes_settings.svh"

package aes_gf_pkg;

  // xtime, reduce by x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] gf_mul2(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (8'h1b & {8{b[7]}});
  endfunction

  function automatic logic [7:0] gf_mul3(input logic [7:0] b);
    return gf_mul2(b) ^ b;
  endfunction

  // one column times the fixed circulant matrix {02 03 01 01}
  function automatic logic [`AES_WORD_BITS-1:0] mix_column(
    input logic [`AES_WORD_BITS-1:0] col
  );
    logic [7:0] b0, b1, b2, b3;
    b0 = col[31:24];
    b1 = col[23:16];
    b2 = col[15:8];
    b3 = col[7:0];
    return {gf_mul2(b0) ^ gf_mul3(b1) ^ b2 ^ b3,
            b0 ^ gf_mul2(b1) ^ gf_mul3(b2) ^ b3,
            b0 ^ b1 ^ gf_mul2(b2) ^ gf_mul3(b3),
            gf_mul3(b0) ^ b1 ^ b2 ^ gf_mul2(b3)};
  endfunction

endpackage

`default_nettype wire

/* aes_round_datapath.sv */
// AES state register with init, SubBytes word write-back,
// main round and final round updates
`default_nettype none
`include "aes_settings.svh"

module aes_round_datapath
  import aes_types_pkg::*;
  import aes_gf_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          reset_n,
  input  wire aes_round_op_e round_op,
  input  wire logic [1:0]    sword_idx,
  input  wire aes_block_t    block,
  input  wire aes_block_t    round_key,
  input  wire aes_word_t     sbox_out,
  output wire aes_word_t     sbox_in,
  output wire aes_block_t    new_block
);

  localparam int NWORDS = `AES_BLOCK_WORDS;
  localparam int NBYTES = `AES_BLOCK_BITS / 8;

  aes_block_t state_reg;
  aes_block_t state_next;
  // after ShiftRows
  aes_block_t sr_block;
  // after ShiftRows and MixColumns
  aes_block_t mc_block;
  // low bit of the column under substitution
  int         sub_lsb;

  // column 0 sits at the top
  assign sub_lsb = (NWORDS - 1 - int'(sword_idx)) * `AES_WORD_BITS;
  assign sbox_in = state_reg[sub_lsb +: `AES_WORD_BITS];

  // -------------------------------------------------------------------------
  // round functions
  // -------------------------------------------------------------------------
  always_comb
  begin
    // byte k = 4*col + row with byte 0 in the top bits
    // row r rotates left by r columns
    for (int c = 0; c < NWORDS; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        sr_block[(NBYTES - 1 - (4*c + r)) * 8 +: 8] =
          state_reg[(NBYTES - 1 - (4*((c + r) % NWORDS) + r)) * 8 +: 8];
      end
    end
    // mix each shifted column
    for (int c = 0; c < NWORDS; c++)
    begin
      mc_block[(NWORDS - 1 - c) * `AES_WORD_BITS +: `AES_WORD_BITS] =
        mix_column(sr_block[(NWORDS - 1 - c) * `AES_WORD_BITS +: `AES_WORD_BITS]);
    end
  end

  // next state select
  always_comb
  begin
    state_next = state_reg;
    case (round_op)
      // initial AddRoundKey on the incoming block
      OP_INIT:
        state_next = block ^ round_key;
      // SubBytes writes back one column per cycle
      OP_SUB:
        state_next[sub_lsb +: `AES_WORD_BITS] = sbox_out;
      OP_MAIN:
        state_next = mc_block ^ round_key;
      // last round skips MixColumns
      OP_FINAL:
        state_next = sr_block ^ round_key;
      default:
        state_next = state_reg;
    endcase
  end

  always_ff @(posedge clk)
  begin
    state_reg <= state_next;
  end

  assign new_block = state_reg;

  // controller only ever issues a defined opcode
  a_op_legal: assert property (@(posedge clk) disable iff (!reset_n)
    round_op inside {OP_HOLD, OP_INIT, OP_SUB, OP_MAIN, OP_FINAL});

endmodule

`default_nettype wire

/* aes_sbox.sv */
// forward AES S-box, one 32-bit word per lookup
`default_nettype none
`include "aes_settings.svh"

module aes_sbox
  import aes_types_pkg::*;
(
  input  wire aes_word_t word_in,
  output wire aes_word_t word_out
);

  // -------------------------------------------------------------------------
  // forward substitution table
  // -------------------------------------------------------------------------
  // entry 0 is the leftmost byte, one row of 16 entries per line
  localparam logic [0:255][7:0] SBOX = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  // -------------------------------------------------------------------------
  // four parallel byte lookups
  // -------------------------------------------------------------------------
  // one table copy per byte lane, all combinational
  genvar i;
  generate
    for (i = 0; i < `AES_WORD_BITS / 8; i++)
    begin : g_byte
      assign word_out[8*i +: 8] = SBOX[word_in[8*i +: 8]];
    end
  endgenerate

endmodule

`default_nettype wire

/* aes_settings.svh */
// AES-128 core sizes: block, column and round-counter widths
// and the round count
`ifndef AES_SETTINGS_SVH
`define AES_SETTINGS_SVH

// state and round key width
`define AES_BLOCK_BITS 128
// one state column
`define AES_WORD_BITS 32
// columns per block
`define AES_BLOCK_WORDS 4
// AES-128 only
`define AES_ROUNDS 10
`define AES_ROUND_BITS 4

`endif

/* aes_types_pkg.sv */
// shared AES types: column and block words, datapath opcodes
// and controller states
`default_nettype none
`include "aes_settings.svh"

package aes_types_pkg;

  // one column, row 0 in the top byte
  typedef logic [`AES_WORD_BITS-1:0] aes_word_t;
  // column 0 in the top word
  typedef logic [`AES_BLOCK_BITS-1:0] aes_block_t;

  // what the datapath does to the state this cycle
  typedef enum logic [2:0] {
    OP_HOLD  = 3'd0,
    OP_INIT  = 3'd1,
    OP_SUB   = 3'd2,
    OP_MAIN  = 3'd3,
    OP_FINAL = 3'd4
  } aes_round_op_e;

  typedef enum logic [1:0] {
    CTRL_IDLE, CTRL_INIT, CTRL_SUB, CTRL_UPDATE
  } aes_ctrl_state_e;

endpackage

`default_nettype wire

/* project.f */
+incdir+.
aes_types_pkg.sv
aes_gf_pkg.sv
aes_sbox.sv
aes_round_datapath.sv
aes_encipher_ctrl.sv
aes_encipher_core.sv
tb_aes_encipher.sv

/* run.sh */
#!/bin/sh
# build the AES-128 encipher testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
  verilator --binary --assert -f project.f --top-module tb_aes_encipher -o sim_aes &&
  ./obj_dir/sim_aes | tee /dev/stderr | grep -x "TEST PASS" > /dev/null &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

/* tb_aes_encipher.sv */
// AES-128 encipher testbench: FIPS-197 round-key tables, handshake stimulus,
// reference timing model, assertions and watchdog
`default_nettype none
`include "aes_settings.svh"

module tb_aes_encipher
  import aes_types_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_BLOCKS = 12;
  // init cycle, then four SubBytes words and one update per round
  localparam int BLOCK_CYCLES = 1 + (`AES_BLOCK_WORDS + 1) * `AES_ROUNDS;
  localparam logic [`AES_ROUND_BITS-1:0] LAST_ROUND = `AES_ROUND_BITS'(`AES_ROUNDS);
  localparam logic [31:0] SEED = 32'd65;

  // ---------------------------------------------------------------------------
  // FIPS-197 vectors, appendix B and appendix C.1
  // ---------------------------------------------------------------------------
  localparam aes_block_t PLAIN_B   = 128'h3243f6a8885a308d313198a2e0370734;
  localparam aes_block_t CIPHER_B  = 128'h3925841d02dc09fbdc118597196a0b32;
  localparam aes_block_t PLAIN_C1  = 128'h00112233445566778899aabbccddeeff;
  localparam aes_block_t CIPHER_C1 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;

  // expanded keys, round 0 first
  localparam aes_block_t KEYS_B [0:10] = '{
    128'h2b7e151628aed2a6abf7158809cf4f3c, 128'ha0fafe1788542cb123a339392a6c7605,
    128'hf2c295f27a96b9435935807a7359f67f, 128'h3d80477d4716fe3e1e237e446d7a883b,
    128'hef44a541a8525b7fb671253bdb0bad00, 128'hd4d1c6f87c839d87caf2b8bc11f915bc,
    128'h6d88a37a110b3efddbf98641ca0093fd, 128'h4e54f70e5f5fc9f384a64fb24ea6dc4f,
    128'head27321b58dbad2312bf5607f8d292f, 128'hac7766f319fadc2128d12941575c006e,
    128'hd014f9a8c9ee2589e13f0cc8b6630ca6
  };
  localparam aes_block_t KEYS_C1 [0:10] = '{
    128'h000102030405060708090a0b0c0d0e0f, 128'hd6aa74fdd2af72fadaa678f1d6ab76fe,
    128'hb692cf0b643dbdf1be9bc5006830b3fe, 128'hb6ff744ed2c2c9bf6c590cbf0469bf41,
    128'h47f7f7bc95353e03f96c32bcfd058dfd, 128'h3caaa3e8a99f9deb50f3af57adf622aa,
    128'h5e390f7df7a69296a7553dc10aa31f6b, 128'h14f9701ae35fe28c440adf4d4ea9c026,
    128'h47438735a41c65b9e016baf4aebf7ad2, 128'h549932d1f08557681093ed9cbe2c974e,
    128'h13111d7fe3944a17f307a78b4d2b30c5
  };

  logic                       clk;
  logic                       reset_n;
  logic                       next;
  aes_block_t                 block;
  aes_block_t                 round_key;
  logic [`AES_ROUND_BITS-1:0] round;
  aes_block_t                 new_block;
  logic                       ready;

  // stimulus side
  logic        vec_sel;
  logic [31:0] rng;
  logic        ready_q;
  int          rise_count;

  // reference timing, counted from the accepting edge
  logic                       model_busy;
  logic                       model_ready;
  logic                       active_vec;
  int                         model_cnt;
  logic [`AES_ROUND_BITS-1:0] exp_round;
  aes_block_t                 exp_cipher;

  aes_encipher_core u_aes_encipher_core (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .block     (block),
    .round_key (round_key),
    .round     (round),
    .new_block (new_block),
    .ready     (ready)
  );

  // key lookup follows the round output in the same cycle
  assign round_key = vec_sel ? KEYS_C1[round] : KEYS_B[round];

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  // ---------------------------------------------------------------------------
  // timing model and checks
  // ---------------------------------------------------------------------------
  always @(posedge clk)
  begin
    if (!reset_n)
    begin
      model_busy  <= 1'b0;
      model_ready <= 1'b0;
      model_cnt   <= 0;
      active_vec  <= 1'b0;
    end
    else if (!model_busy)
    begin
      // start only accepted while idle
      if (next)
      begin
        model_busy  <= 1'b1;
        model_ready <= 1'b0;
        model_cnt   <= 1;
        active_vec  <= vec_sel;
      end
    end
    else if (model_cnt == BLOCK_CYCLES)
    begin
      model_busy  <= 1'b0;
      model_ready <= 1'b1;
      model_cnt   <= 0;
    end
    else
      model_cnt <= model_cnt + 1;
  end

  // round 0 on the init cycle, then five cycles per round
  assign exp_round = model_busy ?
    `AES_ROUND_BITS'((model_cnt + `AES_BLOCK_WORDS - 1) / (`AES_BLOCK_WORDS + 1)) : '0;
  assign exp_cipher = active_vec ? CIPHER_C1 : CIPHER_B;

  // count done edges seen on the DUT
  always @(posedge clk)
  begin
    if (!reset_n)
    begin
      ready_q    <= 1'b0;
      rise_count <= 0;
    end
    else
    begin
      ready_q <= ready;
      if (ready && !ready_q)
        rise_count <= rise_count + 1;
    end
  end

  a_ready: assert property (@(posedge clk) disable iff (!reset_n) ready == model_ready)
    else report_failure($sformatf("FAILED ready: expected %h, got %h",
      $sampled(model_ready), $sampled(ready)));

  a_result: assert property (@(posedge clk) disable iff (!reset_n)
    model_ready |-> new_block == exp_cipher)
    else report_failure($sformatf("FAILED new_block: expected %h, got %h",
      $sampled(exp_cipher), $sampled(new_block)));

  a_round: assert property (@(posedge clk) disable iff (!reset_n) round == exp_round)
    else report_failure($sformatf("FAILED round: expected %h, got %h",
      $sampled(exp_round), $sampled(round)));

  // last key lookup just before done
  a_last_round: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(ready) |-> $past(round) == LAST_ROUND)
    else report_failure("ready rose without the round output reaching the last round");

  // ---------------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------------
  task automatic step_cycle();
    @(posedge clk);
    #10;
  endtask

  task automatic run_block(input logic vec, input int gap);
    int pulse_a;
    int pulse_b;
    int k;
    rng = xorshift32(rng);
    pulse_a = 1 + int'(rng % 32'd50);
    rng = xorshift32(rng);
    pulse_b = 1 + int'(rng % 32'd50);
    repeat (gap) step_cycle();
    vec_sel = vec;
    block   = vec ? PLAIN_C1 : PLAIN_B;
    next    = 1'b1;
    step_cycle();
    // junk on block, only the accepting edge may sample it
    rng   = xorshift32(rng);
    block = {rng, ~rng, rng ^ 32'h5a5a5a5a, {rng[15:0], rng[31:16]}};
    // stray starts while busy
    for (k = 1; k < BLOCK_CYCLES; k++)
    begin
      next = (k == pulse_a) || (k == pulse_b);
      step_cycle();
    end
    next = 1'b0;
    while (!ready)
      step_cycle();
  endtask

  initial
  begin
    int order [NUM_BLOCKS];
    int i;
    int j;
    int tmp;
    reset_n = 1'b0;
    next    = 1'b0;
    block   = '0;
    vec_sel = 1'b0;
    rng     = SEED;
    // half of each vector, then shuffled
    for (i = 0; i < NUM_BLOCKS; i++)
      order[i] = i % 2;
    for (i = NUM_BLOCKS - 1; i > 0; i--)
    begin
      rng      = xorshift32(rng);
      j        = int'(rng % 32'(i + 1));
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    repeat (5) @(posedge clk);
    #10;
    reset_n = 1'b1;
    for (i = 0; i < NUM_BLOCKS; i++)
    begin
      rng = xorshift32(rng);
      run_block(order[i] != 0, int'(rng % 32'd8));
    end
    // let the last result reach the checks
    step_cycle();
    step_cycle();
    if (rise_count == NUM_BLOCKS)
    begin
      $display("TEST PASS");
      $finish;
    end
    else
      report_failure($sformatf("FAILED ready rise count: expected %h, got %h",
        NUM_BLOCKS, rise_count));
  end

  // bounded by the worst-case block length plus reset and idle gaps
  initial
  begin
    repeat (NUM_BLOCKS * 60 + 200) @(posedge clk);
    report_failure("watchdog expired before all blocks completed");
  end

endmodule

`default_nettype wire
